// ==== filelist.f ====
hdl/cpu_pkg.sv
hdl/fetch_sequencer.sv
hdl/inherent_alu.sv
hdl/accumulator_bank.sv
hdl/core6809_top.sv
tests/program_memory.sv
tests/tb_core.sv

// ==== hdl/accumulator_bank.sv ====
// ------------------------------
// Accumulator bank
// Holds A, B and CC and loads ALU results
// ------------------------------

`timescale 1ns/1ps

module accumulator_bank import cpu_pkg::*; (
  input  logic        clk,
  input  logic        reset_b,
  input  acc_update_t update,
  output cpu_regs_t   regs
);

  cpu_regs_t regs_q;

  // ------------------------------
  // Register update
  // ------------------------------
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      // Accumulators clear, CC comes up with E, F and I set
      regs_q.a  <= 8'h00;
      regs_q.b  <= 8'h00;
      regs_q.cc <= CC_RESET;
    end else if (update.valid) begin
      // Every valid update rewrites the full CC byte
      regs_q.cc <= update.cc;
      // Only one accumulator changes per op
      if (update.dest_b) begin
        regs_q.b <= update.value;
      end else begin
        regs_q.a <= update.value;
      end
    end
  end

  // Same view feeds ALU operands and the top-level port
  assign regs = regs_q;

endmodule

// ==== hdl/core6809_top.sv ====
// ------------------------------
// Core top level
// Fetch sequencer feeds the inherent ALU, which updates
// the accumulator bank; registers are visible on regs
// ------------------------------

`timescale 1ns/1ps

module core6809_top import cpu_pkg::*; #(
  parameter addr_t VECTOR_ADDR = VECTOR_RESET_ADDR
) (
  input  logic      clk,
  input  logic      reset_b,
  input  byte_t     data_in,
  output addr_t     addr,
  output cpu_regs_t regs
);

  // Stage-to-stage links
  fetch_t      fetch;
  acc_update_t update;

  // ------------------------------
  // Input side, bus and opcode strobe
  // ------------------------------
  fetch_sequencer #(
    .VECTOR_ADDR(VECTOR_ADDR)
  ) u_fetch (
    .clk     (clk),
    .reset_b (reset_b),
    .data_in (data_in),
    .addr    (addr),
    .fetch   (fetch)
  );

  // Combinational execute on the strobe cycle
  inherent_alu u_alu (
    .fetch  (fetch),
    .regs   (regs),
    .update (update)
  );

  // Output side, loads at the end of the strobe cycle
  accumulator_bank u_bank (
    .clk     (clk),
    .reset_b (reset_b),
    .update  (update),
    .regs    (regs)
  );

endmodule

// ==== hdl/cpu_pkg.sv ====
// ------------------------------
// Shared types and constants for the 6809-style core
// Widths, opcode fields, condition-code bits, reset values
// and the structs passed between the pipeline stages
// ------------------------------

package cpu_pkg;

  // Basic widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 8;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] byte_t;

  // Opcode split into row (mode / register group) and column (operation)
  typedef struct packed {
    logic [3:0] row;
    logic [3:0] col;
  } opcode_t;

  // Inherent accumulator rows
  localparam logic [3:0] ROW_ACC_A = 4'h4;
  localparam logic [3:0] ROW_ACC_B = 4'h5;

  // Column codes of the supported inherent operations
  localparam logic [3:0] COL_CLR = 4'hF;
  localparam logic [3:0] COL_INC = 4'hC;
  localparam logic [3:0] COL_ASL = 4'h8;
  localparam logic [3:0] COL_ASR = 4'h7;
  localparam logic [3:0] COL_LSR = 4'h4;
  localparam logic [3:0] COL_COM = 4'h3;

  typedef enum logic [2:0] {
    ALU_NONE,
    ALU_CLR,
    ALU_INC,
    ALU_ASL,
    ALU_ASR,
    ALU_LSR,
    ALU_COM
  } alu_op_e;

  // Condition-code bit positions, E in the MSB
  localparam int unsigned CC_E = 7;
  localparam int unsigned CC_F = 6;
  localparam int unsigned CC_H = 5;
  localparam int unsigned CC_I = 4;
  localparam int unsigned CC_N = 3;
  localparam int unsigned CC_Z = 2;
  localparam int unsigned CC_V = 1;
  localparam int unsigned CC_C = 0;

  // E, F and I set out of reset
  localparam byte_t CC_RESET = 8'hD0;

  // Big-endian reset vector lives at FFFE/FFFF
  localparam addr_t VECTOR_RESET_ADDR = 16'hFFFE;

  // Fetch side to ALU, one-cycle strobe per opcode
  typedef struct packed {
    logic    strobe;
    opcode_t opcode;
  } fetch_t;

  // ALU to accumulator bank
  typedef struct packed {
    logic  valid;
    logic  dest_b;
    byte_t value;
    byte_t cc;
  } acc_update_t;

  // Register view
  typedef struct packed {
    byte_t a;
    byte_t b;
    byte_t cc;
  } cpu_regs_t;

endpackage

// ==== hdl/fetch_sequencer.sv ====
// ------------------------------
// Reset-vector load and opcode fetch
// Reads the vector high then low byte, then walks the
// program one byte per cycle and strobes each opcode out
// ------------------------------

`timescale 1ns/1ps

module fetch_sequencer import cpu_pkg::*; #(
  parameter addr_t VECTOR_ADDR = VECTOR_RESET_ADDR
) (
  input  logic   clk,
  input  logic   reset_b,
  input  byte_t  data_in,
  output addr_t  addr,
  output fetch_t fetch
);

  // State names what has been loaded so far
  typedef enum logic [1:0] {
    ST_RESET,
    ST_VEC_HI,
    ST_VEC_LO,
    ST_FETCH
  } state_e;

  state_e  state_q;
  state_e  state_d;
  addr_t   pc_q;
  addr_t   pc_d;
  addr_t   addr_d;
  logic    capture;
  logic    strobe_q;
  opcode_t opcode_q;

  // Opcode on the bus once the vector is complete
  assign capture = (state_q == ST_VEC_LO) || (state_q == ST_FETCH);

  // ------------------------------
  // Next state, PC and bus address
  // ------------------------------
  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    addr_d  = addr;
    case (state_q)
      ST_RESET: begin
        // Bus shows FFFE, take the vector MSB
        state_d = ST_VEC_HI;
        pc_d    = {data_in, pc_q[7:0]};
        addr_d  = VECTOR_ADDR + 16'd1;
      end
      ST_VEC_HI: begin
        // Bus shows FFFF, LSB completes the vector
        state_d = ST_VEC_LO;
        addr_d  = {pc_q[15:8], data_in};
        pc_d    = {pc_q[15:8], data_in} + 16'd1;
      end
      ST_VEC_LO, ST_FETCH: begin
        // PC already points one past the bus address
        state_d = ST_FETCH;
        addr_d  = pc_q;
        pc_d    = pc_q + 16'd1;
      end
      default: begin
        state_d = ST_RESET;
      end
    endcase
  end

  // Control flops
  always_ff @(posedge clk or negedge reset_b) begin
    if (!reset_b) begin
      state_q  <= ST_RESET;
      pc_q     <= '0;
      addr     <= VECTOR_ADDR;
      strobe_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      pc_q     <= pc_d;
      addr     <= addr_d;
      // Strobe follows the capture edge by one cycle
      strobe_q <= capture;
    end
  end

  // Opcode holding register
  always_ff @(posedge clk) begin
    if (capture) begin
      opcode_q <= opcode_t'(data_in);
    end
  end

  assign fetch = '{strobe: strobe_q, opcode: opcode_q};

endmodule

// ==== hdl/inherent_alu.sv ====
// ------------------------------
// Inherent accumulator ALU
// Decodes the strobed opcode and computes the new
// accumulator value and condition codes in one cycle
// ------------------------------

`timescale 1ns/1ps

module inherent_alu import cpu_pkg::*; (
  input  fetch_t      fetch,
  input  cpu_regs_t   regs,
  output acc_update_t update
);

  opcode_t    opcode;
  alu_op_e    op;
  logic       row_ok;
  logic       dest_b;
  byte_t      src;
  logic [8:0] result;
  byte_t      cc_next;

  assign opcode = fetch.opcode;

  // ------------------------------
  // Decode
  // ------------------------------

  // Row 4 is A, row 5 is B, same register in and out
  assign row_ok = (opcode.row == ROW_ACC_A) || (opcode.row == ROW_ACC_B);
  assign dest_b = (opcode.row == ROW_ACC_B);
  assign src    = dest_b ? regs.b : regs.a;

  // Column picks the operation
  always_comb begin
    case (opcode.col)
      COL_CLR: op = ALU_CLR;
      COL_INC: op = ALU_INC;
      COL_ASL: op = ALU_ASL;
      COL_ASR: op = ALU_ASR;
      COL_LSR: op = ALU_LSR;
      COL_COM: op = ALU_COM;
      default: op = ALU_NONE;
    endcase
  end

  // ------------------------------
  // Datapath
  // ------------------------------

  // Bit 8 carries the outgoing carry where the op has one
  always_comb begin
    case (op)
      ALU_CLR: result = 9'h000;
      ALU_INC: result = {1'b0, src} + 9'h001;
      // Old bit 7 shifts out into bit 8
      ALU_ASL: result = {src, 1'b0};
      // Sign bit replicated, bit 0 to carry
      ALU_ASR: result = {src[0], src[7], src[7:1]};
      // Zero fill from the top
      ALU_LSR: result = {src[0], 1'b0, src[7:1]};
      // COM always sets carry
      ALU_COM: result = {1'b1, ~src};
      default: result = {1'b0, src};
    endcase
  end

  // ------------------------------
  // Condition codes
  // ------------------------------
  always_comb begin
    // E, F, H, I pass through untouched
    cc_next = regs.cc;

    // N and Z straight from the result byte
    cc_next[CC_N] = result[7];
    cc_next[CC_Z] = (result[7:0] == 8'h00);

    // Overflow rules differ per op
    case (op)
      ALU_CLR, ALU_COM: begin
        cc_next[CC_V] = 1'b0;
      end
      ALU_INC: begin
        // 7F -> 80 is the only signed overflow
        cc_next[CC_V] = (result[7:0] == 8'h80);
      end
      ALU_ASL: begin
        cc_next[CC_V] = src[7] ^ src[6];
      end
      default: begin
        cc_next[CC_V] = regs.cc[CC_V];
      end
    endcase

    // INC leaves carry alone, everything else takes bit 8
    cc_next[CC_C] = (op == ALU_INC) ? regs.cc[CC_C] : result[8];
  end

  // Only the six recognized ops on A or B produce an update
  assign update = '{
    valid:  fetch.strobe && row_ok && (op != ALU_NONE),
    dest_b: dest_b,
    value:  result[7:0],
    cc:     cc_next
  };

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

# Compile RTL and testbench into one executable
verilator --binary --timing --assert \
  --top-module tb_core \
  -f filelist.f \
  -Mdir obj_dir \
  -o tb_core_sim

# Run and keep the log for the result search
./obj_dir/tb_core_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: testbench passed"
  exit 0
else
  echo "run_sim: testbench failed"
  exit 1
fi

// ==== tests/program_memory.sv ====
// ------------------------------
// Read-only program memory for the core testbench
// Big-endian reset vector at FFFE/FFFF, program image
// starting at VECTOR, NOP (12) at every other address
// ------------------------------

`timescale 1ns/1ps

module program_memory import cpu_pkg::*; #(
  parameter addr_t VECTOR   = 16'h1000,
  parameter int    PROG_LEN = 48
) (
  input  addr_t                 addr,
  input  logic [PROG_LEN*8-1:0] image,
  output byte_t                 data
);

  addr_t offset;

  // Byte offset into the program image
  assign offset = addr - VECTOR;

  // Answers in the same cycle as the address
  // Image is at most 64 bytes deep
  always_comb begin
    if (addr == VECTOR_RESET_ADDR) begin
      data = VECTOR[15:8];
    end else if (addr == VECTOR_RESET_ADDR + 16'd1) begin
      data = VECTOR[7:0];
    end else if (offset < 16'(PROG_LEN)) begin
      data = image[{offset[5:0], 3'b000} +: 8];
    end else begin
      data = 8'h12;
    end
  end

endmodule

// ==== tests/tb_core.sv ====
// ------------------------------
// Testbench for the 6809-style core
// Reset, vector load, a directed opcode block and a seeded
// random block, with regs compared against a model
// ------------------------------

`timescale 1ns/1ps

module tb_core import cpu_pkg::*; ();

  localparam addr_t     VECTOR         = 16'h1000;
  localparam int        RESET_CYCLES   = 16;
  localparam int        DIRECTED_BYTES = 16;
  localparam int        PROG_BYTES     = 48;
  // Vector cycles, program, then a short drain
  localparam int        RUN_CYCLES     = 2 + PROG_BYTES + 4;
  localparam int        TIMEOUT_CYCLES = RESET_CYCLES + 2 + PROG_BYTES + 20;
  localparam cpu_regs_t RESET_REGS     = '{a: 8'h00, b: 8'h00, cc: 8'hD0};

  logic                    clk;
  logic                    reset_b;
  byte_t                   data_in;
  addr_t                   addr;
  cpu_regs_t               regs;
  logic [PROG_BYTES*8-1:0] image;

  cpu_regs_t model;
  cpu_regs_t expect_q[$];
  int        addr_errors;
  int        reg_errors;
  int        flag_errors;
  int        cycle_count;
  int        seed;

  core6809_top #(
    .VECTOR_ADDR(VECTOR_RESET_ADDR)
  ) uut (
    .clk     (clk),
    .reset_b (reset_b),
    .data_in (data_in),
    .addr    (addr),
    .regs    (regs)
  );

  program_memory #(
    .VECTOR   (VECTOR),
    .PROG_LEN (PROG_BYTES)
  ) mem (
    .addr  (addr),
    .image (image),
    .data  (data_in)
  );

  // ------------------------------
  // Program image and model
  // ------------------------------

  // Directed block first, then random picks from 15 opcodes
  task automatic build_program();
    byte_t      directed [0:15];
    byte_t      pool [0:14];
    logic [6:0] k;
    logic [3:0] pick;
    // A side covers COM, INC from FF and from 7F, LSR to 7F and the shifts
    // B side shifts then clears
    // DECA has a valid row only and CLR indexed a valid column only
    directed = '{8'h43, 8'h4C, 8'h43, 8'h44, 8'h4C, 8'h47, 8'h48, 8'h48,
                 8'h53, 8'h58, 8'h4A, 8'h54, 8'h58, 8'h6F, 8'h5F, 8'h86};
    pool = '{8'h4F, 8'h4C, 8'h48, 8'h47, 8'h44, 8'h43, 8'h5F, 8'h5C,
             8'h58, 8'h57, 8'h54, 8'h53, 8'h12, 8'h3A, 8'h86};
    for (k = 7'd0; k < 7'(PROG_BYTES); k = k + 7'd1) begin
      if (k < 7'(DIRECTED_BYTES)) begin
        image[{k[5:0], 3'b000} +: 8] = directed[k[3:0]];
      end else begin
        pick = 4'($unsigned($random(seed)) % 32'd15);
        image[{k[5:0], 3'b000} +: 8] = pool[pick];
      end
    end
  endtask

  // Byte the memory holds at a program address
  function automatic byte_t program_byte(addr_t a);
    addr_t off;
    byte_t val;
    off = a - VECTOR;
    val = 8'h12;
    if (off < 16'(PROG_BYTES)) begin
      val = image[{off[5:0], 3'b000} +: 8];
    end
    return val;
  endfunction

  // Inherent accumulator ops, rows 4 and 5 only
  function automatic cpu_regs_t apply_op(cpu_regs_t cur, byte_t opc);
    cpu_regs_t nxt;
    byte_t     src;
    byte_t     res;
    byte_t     cc;
    logic      hit;
    nxt = cur;
    cc  = cur.cc;
    src = (opc[7:4] == 4'h5) ? cur.b : cur.a;
    res = src;
    hit = (opc[7:4] == 4'h4) || (opc[7:4] == 4'h5);
    case (opc[3:0])
      4'hF: begin
        res      = 8'h00;
        cc[CC_V] = 1'b0;
        cc[CC_C] = 1'b0;
      end
      4'hC: begin
        res      = src + 8'h01;
        cc[CC_V] = (src == 8'h7F);
      end
      4'h8: begin
        res      = {src[6:0], 1'b0};
        cc[CC_V] = src[7] ^ src[6];
        cc[CC_C] = src[7];
      end
      4'h7: begin
        res      = {src[7], src[7:1]};
        cc[CC_C] = src[0];
      end
      4'h4: begin
        res      = {1'b0, src[7:1]};
        cc[CC_C] = src[0];
      end
      4'h3: begin
        res      = ~src;
        cc[CC_V] = 1'b0;
        cc[CC_C] = 1'b1;
      end
      default: hit = 1'b0;
    endcase
    // N and Z from the result byte in every case
    cc[CC_N] = res[7];
    cc[CC_Z] = (res == 8'h00);
    if (hit) begin
      nxt.cc = cc;
      if (opc[7:4] == 4'h5) begin
        nxt.b = res;
      end else begin
        nxt.a = res;
      end
    end
    return nxt;
  endfunction

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic inspect_reset();
    assert (addr == 16'hFFFE) else begin
      $display("CHECK FAILED in reset: addr got %h expected fffe", addr);
      addr_errors++;
    end
    assert (regs == RESET_REGS) else begin
      $display("CHECK FAILED in reset: regs got %h expected %h", regs, RESET_REGS);
      reg_errors++;
    end
  endtask

  task automatic compare_cycle(input int n);
    addr_t     exp_addr;
    cpu_regs_t exp_regs;
    case (n)
      0: exp_addr = 16'hFFFE;
      1: exp_addr = 16'hFFFF;
      default: exp_addr = VECTOR + 16'(n - 2);
    endcase
    assert (addr == exp_addr) else begin
      $display("CHECK FAILED cycle %0d: addr got %h expected %h", n, addr, exp_addr);
      addr_errors++;
    end
    // Opcode on the bus now lands in regs two edges later
    if (n >= 2) begin
      model = apply_op(model, program_byte(exp_addr));
    end
    expect_q.push_back(model);
    exp_regs = expect_q.pop_front();
    assert (regs == exp_regs) else begin
      $display("CHECK FAILED cycle %0d: regs got a=%h b=%h cc=%h expected a=%h b=%h cc=%h",
               n, regs.a, regs.b, regs.cc, exp_regs.a, exp_regs.b, exp_regs.cc);
      reg_errors++;
    end
    // E, F, I stay set and H stays clear
    assert (regs.cc[7:4] == 4'hD) else begin
      $display("CHECK FAILED cycle %0d: regs.cc[7:4] got %h expected d", n, regs.cc[7:4]);
      flag_errors++;
    end
  endtask

  // ------------------------------
  // Clock, watchdog and main flow
  // ------------------------------
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    reset_b     = 1'b0;
    addr_errors = 0;
    reg_errors  = 0;
    flag_errors = 0;
    seed        = 32'he1cf_3b2a;
    model       = RESET_REGS;
    build_program();
    // Two reset images cover the fetch-to-regs latency
    expect_q.push_back(RESET_REGS);
    expect_q.push_back(RESET_REGS);
    repeat (RESET_CYCLES - 1) begin
      @(negedge clk);
      inspect_reset();
    end
    @(posedge clk);
    #1 reset_b = 1'b1;
    // Mid-cycle sampling keeps clear of the rising edge
    for (int n = 0; n < RUN_CYCLES; n++) begin
      @(negedge clk);
      compare_cycle(n);
    end
    $display("Errors: addr %0d, regs %0d, flags %0d", addr_errors, reg_errors, flag_errors);
    if (addr_errors + reg_errors + flag_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
